// File: sh_pkg.sv
`default_nettype none

package sh_pkg;

	localparam int DATA_W = 32;
	localparam int LANE_N = 4;

	localparam logic [DATA_W-1:0] SR_MASK  = 32'h0000_03F3;
	localparam logic [DATA_W-1:0] SR_RESET = 32'h0000_00F0;

	typedef enum logic [2:0] {
		ADD,
		LOG,
		SHIFT,
		EXT,
		STC,
		LDC,
		LOAD,
		STORE
	} op_class_e;

	typedef logic [3:0] alu_code_t;

	// ADD code bits [3:2] pick the T source
	localparam int         ADD_SUB_BIT = 0;
	localparam int         ADD_CIN_BIT = 1;
	localparam logic [1:0] T_SRC_NONE  = 2'd0;
	localparam logic [1:0] T_SRC_CMP   = 2'd1;
	localparam logic [1:0] T_SRC_CARRY = 2'd2;
	localparam logic [1:0] T_SRC_OVF   = 2'd3;

	localparam alu_code_t LOG_AND   = 4'h0;
	localparam alu_code_t LOG_OR    = 4'h1;
	localparam alu_code_t LOG_XOR   = 4'h2;
	localparam alu_code_t LOG_TST   = 4'h3;

	localparam alu_code_t SHL_ARITH = 4'h0;
	localparam alu_code_t SHR_ARITH = 4'h1;
	localparam alu_code_t SHL_ROT   = 4'h2;
	localparam alu_code_t SHR_ROT   = 4'h3;

	localparam alu_code_t EXT_UB    = 4'h0;
	localparam alu_code_t EXT_UW    = 4'h1;
	localparam alu_code_t EXT_SB    = 4'h2;
	localparam alu_code_t EXT_SW    = 4'h3;

	typedef enum logic [2:0] {EQ, HS, GE, HI, GT} cmp_mode_e;

	typedef enum logic [1:0] {BYTE, WORD, LONG} mem_size_e;

	// For LOAD and STORE a is the address, b the store data
	typedef struct packed {
		op_class_e         cls;
		alu_code_t         code;
		cmp_mode_e         cmp;
		mem_size_e         size;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
	} exec_cmd_t;

	typedef struct packed {
		logic [DATA_W-1:0] word;
		logic              t;
	} exec_res_t;

	typedef struct packed {
		logic [21:0] rsv_hi;
		logic        m;
		logic        q;
		logic [3:0]  i;
		logic [1:0]  rsv_lo;
		logic        s;
		logic        t;
	} sr_fields_t;

	typedef union packed {
		logic [31:0] word;
		sr_fields_t  f;
	} sr_word_u;

	typedef struct packed {
		logic [DATA_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              wr;
		logic [LANE_N-1:0] lanes;
		logic              req;
	} bus_req_t;

endpackage

`default_nettype wire

// File: sh_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sh_alu
	import sh_pkg::*;
(
	input  exec_cmd_t         cmd,
	input  logic              t_in,
	output logic [DATA_W-1:0] result,
	output logic              t_out
);

	logic [DATA_W-1:0] b_eff;
	logic              cin;
	logic [DATA_W-1:0] sum;
	logic              cout;
	logic              ovf;
	logic              eq;
	logic              ge;
	logic              cmp_t;
	logic              add_t;
	logic [DATA_W-1:0] log_res;
	logic [DATA_W-1:0] shift_res;
	logic              shift_t;
	logic [DATA_W-1:0] ext_res;

	//********************
	// Adder
	//********************
	assign b_eff = cmd.code[ADD_SUB_BIT] ? ~cmd.b : cmd.b;
	// Borrow enters inverted when subtracting
	assign cin = cmd.code[ADD_CIN_BIT] ? (t_in ^ cmd.code[ADD_SUB_BIT]) : cmd.code[ADD_SUB_BIT];
	assign {cout, sum} = {1'b0, cmd.a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin};

	assign ovf = (cmd.a[DATA_W-1] == b_eff[DATA_W-1]) && (sum[DATA_W-1] != cmd.a[DATA_W-1]);
	assign eq  = (sum == '0);
	assign ge  = (sum[DATA_W-1] == ovf);

	always_comb begin
		case (cmd.cmp)
			EQ:      cmp_t = eq;
			HS:      cmp_t = cout;
			GE:      cmp_t = ge;
			HI:      cmp_t = cout & ~eq;
			GT:      cmp_t = ge & ~eq;
			default: cmp_t = 1'b0;
		endcase

		case (cmd.code[3:2])
			T_SRC_NONE:  add_t = t_in;
			T_SRC_CMP:   add_t = cmp_t;
			T_SRC_CARRY: add_t = cout ^ cmd.code[ADD_SUB_BIT];
			T_SRC_OVF:   add_t = ovf;
		endcase
	end

	//********************
	// Logic, shift, extend
	//********************
	always_comb begin
		case (cmd.code)
			LOG_AND: log_res = cmd.a & cmd.b;
			LOG_OR:  log_res = cmd.a | cmd.b;
			LOG_XOR: log_res = cmd.a ^ cmd.b;
			default: log_res = cmd.a;
		endcase

		case (cmd.code)
			SHL_ARITH: {shift_t, shift_res} = {cmd.a, 1'b0};
			SHR_ARITH: {shift_res, shift_t} = {cmd.a[DATA_W-1], cmd.a};
			SHL_ROT:   {shift_t, shift_res} = {cmd.a, t_in};
			SHR_ROT:   {shift_res, shift_t} = {t_in, cmd.a};
			default:   {shift_t, shift_res} = {t_in, cmd.a};
		endcase

		case (cmd.code)
			EXT_UB:  ext_res = {{(DATA_W-8){1'b0}}, cmd.a[7:0]};
			EXT_UW:  ext_res = {{(DATA_W-16){1'b0}}, cmd.a[15:0]};
			EXT_SB:  ext_res = {{(DATA_W-8){cmd.a[7]}}, cmd.a[7:0]};
			EXT_SW:  ext_res = {{(DATA_W-16){cmd.a[15]}}, cmd.a[15:0]};
			default: ext_res = cmd.a;
		endcase
	end

	always_comb begin
		case (cmd.cls)
			ADD: begin
				result = sum;
				t_out  = add_t;
			end
			LOG: begin
				result = log_res;
				t_out  = (cmd.code == LOG_TST) ? ~|(cmd.a & cmd.b) : t_in;
			end
			SHIFT: begin
				result = shift_res;
				t_out  = shift_t;
			end
			EXT: begin
				result = ext_res;
				t_out  = t_in;
			end
			// LDC word passes through here
			default: begin
				result = cmd.a;
				t_out  = t_in;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: sh_sr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module sh_sr_unit
	import sh_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              advance,
	input  op_class_e         cmd_class,
	input  logic [DATA_W-1:0] ld_word,
	input  logic              t_new,
	output sr_word_u          sr
);

	// Interrupt mask comes up at level 15
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sr.word <= SR_RESET;
		end else if (advance) begin
			case (cmd_class)
				LDC: begin
					sr.word <= ld_word & SR_MASK;
				end
				ADD,
				LOG,
				SHIFT: begin
					sr.f.t <= t_new;
				end
				default: begin
					sr.word <= sr.word;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sh_mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module sh_mem_align
	import sh_pkg::*;
(
	input  mem_size_e         size,
	input  logic [1:0]        addr_lo,
	input  logic [DATA_W-1:0] wdata_in,
	input  logic [DATA_W-1:0] rdata_in,
	output logic [LANE_N-1:0] lanes,
	output logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

	logic [4:0]        rd_shift;
	logic [DATA_W-1:0] rd_shifted;

	// Big-endian lanes, lane 3 is byte 0
	always_comb begin
		case (size)
			BYTE: begin
				lanes    = {1'b1, {(LANE_N-1){1'b0}}} >> addr_lo;
				wdata    = {LANE_N{wdata_in[7:0]}};
				rd_shift = {~addr_lo, 3'b000};
			end
			WORD: begin
				lanes    = addr_lo[1] ? 4'b0011 : 4'b1100;
				wdata    = {2{wdata_in[15:0]}};
				rd_shift = {~addr_lo[1], 4'b0000};
			end
			default: begin
				lanes    = {LANE_N{1'b1}};
				wdata    = wdata_in;
				rd_shift = 5'd0;
			end
		endcase
	end

	assign rd_shifted = rdata_in >> rd_shift;

	// Loads always sign extend
	always_comb begin
		case (size)
			BYTE:    rdata = {{(DATA_W-8){rd_shifted[7]}}, rd_shifted[7:0]};
			WORD:    rdata = {{(DATA_W-16){rd_shifted[15]}}, rd_shifted[15:0]};
			default: rdata = rd_shifted;
		endcase
	end

endmodule

`default_nettype wire

// File: sh_ma_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sh_ma_ctrl
	import sh_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              ex_valid,
	input  exec_cmd_t         ex_cmd,
	input  exec_res_t         ex_res,
	input  logic              bus_wait,
	input  logic [DATA_W-1:0] bus_rdata,
	output logic              stall,
	output bus_req_t          bus,
	output logic              res_valid,
	output exec_res_t         res
);

	typedef enum logic {IDLE, ACCESS} ma_state_e;

	ma_state_e         state;
	exec_cmd_t         ma_cmd;
	exec_res_t         ma_res;
	logic              ex_mem;
	logic              advance;
	logic              done;
	logic [LANE_N-1:0] lanes;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;

	assign ex_mem  = ex_cmd.cls inside {LOAD, STORE};
	assign done    = (state == ACCESS) & ~bus_wait;
	// A plain result behind a finishing access waits one cycle to keep order
	assign stall   = (state == ACCESS) & (bus_wait | (ex_valid & ~ex_mem));
	assign advance = ex_valid & ~stall;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= IDLE;
			res_valid <= 1'b0;
		end else begin
			res_valid <= done | (advance & ~ex_mem);
			if (advance && ex_mem) begin
				state <= ACCESS;
			end else if (done) begin
				state <= IDLE;
			end
		end
	end

	//********************
	// MA register and result
	//********************
	always_ff @(posedge CLK) begin
		if (advance && ex_mem) begin
			ma_cmd <= ex_cmd;
			ma_res <= ex_res;
		end
		if (done) begin
			res.word <= (ma_cmd.cls == LOAD) ? rdata : ma_res.word;
			res.t    <= ma_res.t;
		end else if (advance && !ex_mem) begin
			res <= ex_res;
		end
	end

	sh_mem_align u_align (
		.size     (ma_cmd.size),
		.addr_lo  (ma_cmd.a[1:0]),
		.wdata_in (ma_cmd.b),
		.rdata_in (bus_rdata),
		.lanes    (lanes),
		.wdata    (wdata),
		.rdata    (rdata)
	);

	always_comb begin
		bus.addr  = ma_cmd.a;
		bus.wdata = wdata;
		bus.wr    = (ma_cmd.cls == STORE);
		bus.lanes = lanes;
		bus.req   = (state == ACCESS);
	end

endmodule

`default_nettype wire

// File: sh_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module sh_exec_core
	import sh_pkg::*;
(
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              cmd_valid,
	input  exec_cmd_t         cmd,
	output logic              cmd_ready,
	output logic              res_valid,
	output exec_res_t         res,
	output bus_req_t          bus,
	input  logic [DATA_W-1:0] bus_rdata,
	input  logic              bus_wait
);

	logic              ex_valid;
	exec_cmd_t         ex_cmd;
	exec_res_t         ex_res;
	logic [DATA_W-1:0] alu_result;
	logic              alu_t;
	sr_word_u          sr;
	logic              stall;
	logic              advance;

	assign cmd_ready = ~stall;
	assign advance   = ex_valid & ~stall;

	//********************
	// EX register
	//********************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_valid <= 1'b0;
		end else if (!stall) begin
			ex_valid <= cmd_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (!stall && cmd_valid) begin
			ex_cmd <= cmd;
		end
	end

	sh_alu u_alu (
		.cmd    (ex_cmd),
		.t_in   (sr.f.t),
		.result (alu_result),
		.t_out  (alu_t)
	);

	always_comb begin
		case (ex_cmd.cls)
			STC:         ex_res.word = sr.word;
			LOAD, STORE: ex_res.word = ex_cmd.a;
			default:     ex_res.word = alu_result;
		endcase
		// T as it stands once the command has left EX
		ex_res.t = (ex_cmd.cls == LDC) ? alu_result[0] : alu_t;
	end

	sh_sr_unit u_sr (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.advance   (advance),
		.cmd_class (ex_cmd.cls),
		.ld_word   (alu_result),
		.t_new     (alu_t),
		.sr        (sr)
	);

	sh_ma_ctrl u_ma (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ex_valid  (ex_valid),
		.ex_cmd    (ex_cmd),
		.ex_res    (ex_res),
		.bus_wait  (bus_wait),
		.bus_rdata (bus_rdata),
		.stall     (stall),
		.bus       (bus),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

`default_nettype wire

// File: tb_sh_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sh_exec_core
	import sh_pkg::*;
();

	logic              CLK;
	logic              RST_N;
	logic              cmd_valid;
	exec_cmd_t         cmd;
	logic              cmd_ready;
	logic              res_valid;
	exec_res_t         res;
	bus_req_t          bus;
	logic [DATA_W-1:0] bus_rdata;
	logic              bus_wait;

	logic [DATA_W-1:0] mem [0:63];
	exec_cmd_t         cmd_list[$];
	exec_res_t         exp_q[$];
	string             name_q[$];
	int                seed = 32'hfbbd_9b74;
	int                issue_idx = 0;
	int                n_cmds = 0;
	int                n_done = 0;
	int                n_pass = 0;
	int                n_fail = 0;
	int                cycles = 0;
	int                limit = 100;

	sh_exec_core UUT (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.res_valid (res_valid),
		.res       (res),
		.bus       (bus),
		.bus_rdata (bus_rdata),
		.bus_wait  (bus_wait)
	);

	always #50 CLK = ~CLK;

	task automatic load_golden();
		int                fd;
		int                n;
		string             name;
		logic [2:0]        cls;
		logic [3:0]        code;
		logic [2:0]        cmp;
		logic [1:0]        size;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] er;
		logic              et;
		logic [8*160-1:0]  skip;
		exec_cmd_t         c;
		exec_res_t         r;
		fd = $fopen("sh_exec_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sh_exec_golden.txt, no commands were loaded");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", name);
				if (n == 1 && name.getc(0) == "#") begin
					n = $fgets(skip, fd);
				end else if (n == 1) begin
					n = $fscanf(fd, "%d %h %d %d %h %h %h %d",
						cls, code, cmp, size, a, b, er, et);
					if (n != 8) begin
						$display("Golden line for %s could not be parsed", name);
						n_fail++;
					end else begin
						c.cls  = op_class_e'(cls);
						c.code = code;
						c.cmp  = cmp_mode_e'(cmp);
						c.size = mem_size_e'(size);
						c.a    = a;
						c.b    = b;
						r.word = er;
						r.t    = et;
						cmd_list.push_back(c);
						exp_q.push_back(r);
						name_q.push_back(name);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_result(input exec_res_t got);
		exec_res_t want;
		string     tname;
		if (exp_q.size() == 0) begin
			$display("Result %h arrived with no command left to match it", got.word);
			n_fail++;
		end else begin
			want  = exp_q.pop_front();
			tname = name_q.pop_front();
			n_done++;
			if (got !== want) begin
				$display("[ERROR] %s: expected %h t=%0b, actual %h t=%0b",
					tname, want.word, want.t, got.word, got.t);
				n_fail++;
			end else begin
				$display("ok      %s: %h t=%0b", tname, got.word, got.t);
				n_pass++;
			end
		end
	endtask

	//********************
	// Command driver
	//********************
	always @(posedge CLK) begin
		if (cmd_valid && cmd_ready) begin
			issue_idx = issue_idx + 1;
		end
		if (RST_N && issue_idx < n_cmds) begin
			cmd_valid <= 1'b1;
			cmd       <= cmd_list[issue_idx];
		end else begin
			cmd_valid <= 1'b0;
		end
	end

	//********************
	// Bus memory
	//********************
	assign bus_rdata = mem[bus.addr[7:2]];

	always @(posedge CLK) begin
		if (bus.req && !bus_wait && bus.wr) begin
			for (int l = 0; l < LANE_N; l++) begin
				if (bus.lanes[l]) begin
					mem[bus.addr[7:2]][8*l +: 8] <= bus.wdata[8*l +: 8];
				end
			end
		end
		// Wait state about half the time
		bus_wait <= ($random(seed) & 1) != 0;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (RST_N && res_valid) begin
			check_result(res);
		end
	end

	initial begin
		CLK       = 1'b0;
		RST_N     = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		bus_wait  = 1'b0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = '0;
		end
		load_golden();
		n_cmds = cmd_list.size();
		limit  = 20 * n_cmds + 100;
		repeat (10) @(posedge CLK);
		RST_N <= 1'b1;
		while (n_done < n_cmds && cycles < limit) begin
			@(negedge CLK);
		end
		if (n_done < n_cmds) begin
			$display("Timeout with %0d of %0d results after %0d cycles",
				n_done, n_cmds, cycles);
		end else begin
			// Catch any extra result
			repeat (4) @(negedge CLK);
		end
		$display("Results: %0d passed, %0d failed, %0d missing",
			n_pass, n_fail, n_cmds - n_done);
		if (n_cmds > 0 && n_done == n_cmds && n_fail == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sh_exec_golden.txt
# name class code cmp size a b expected_word expected_t (code, a, b, word in hex)
# class 0 ADD 1 LOG 2 SHIFT 3 EXT 4 STC 5 LDC 6 LOAD 7 STORE, cmp 0 EQ to 4 GT, size 0 B 1 W 2 L
stc_reset     4 0 0 0 00000000 00000000 000000F0 0
add_plain     0 0 0 0 00000005 00000007 0000000C 0
addc_cout     0 A 0 0 FFFFFFFF 00000001 00000000 1
addc_cin      0 A 0 0 00000010 00000020 00000031 0
sub_plain     0 1 0 0 00000010 00000003 0000000D 0
subc_borrow   0 B 0 0 00000001 00000002 FFFFFFFF 1
subc_bin      0 B 0 0 00000005 00000002 00000002 0
cmp_eq        0 5 0 0 12345678 12345678 00000000 1
cmp_ge_sign   0 5 2 0 80000000 7FFFFFFF 00000001 0
cmp_hs_sign   0 5 1 0 80000000 7FFFFFFF 00000001 1
cmp_hi_equal  0 5 3 0 FFFFFFFF FFFFFFFF 00000000 0
cmp_gt_neg    0 5 4 0 FFFFFFFF 80000000 7FFFFFFF 1
cmp_gt_false  0 5 4 0 00000001 00000002 FFFFFFFF 0
log_and       1 0 0 0 F0F0F0F0 FF00FF00 F000F000 0
log_or        1 1 0 0 F0F0F0F0 0F0F0000 FFFFF0F0 0
log_xor       1 2 0 0 FFFF0000 0F0F0F0F F0F00F0F 0
tst_zero      1 3 0 0 0000FF00 000000FF 0000FF00 1
shll          2 0 0 0 40000001 00000000 80000002 0
shar          2 1 0 0 80000003 00000000 C0000001 1
rotcr         2 3 0 0 00000002 00000000 80000001 0
rotcl         2 2 0 0 80000000 00000000 00000000 1
exts_b        3 2 0 0 00000080 00000000 FFFFFF80 1
extu_w        3 1 0 0 FFFF8001 00000000 00008001 1
st_long       7 0 0 2 00000010 11223344 00000010 1
st_byte       7 0 0 0 00000011 000000A5 00000011 1
st_word       7 0 0 1 00000016 0000BEEF 00000016 1
ld_long       6 0 0 2 00000010 00000000 11A53344 1
ld_byte       6 0 0 0 00000011 00000000 FFFFFFA5 1
ld_word       6 0 0 1 00000016 00000000 FFFFBEEF 1
ldc_all       5 0 0 0 FFFFFFFF 00000000 FFFFFFFF 1
stc_masked    4 0 0 0 00000000 00000000 000003F3 1

// File: build.f
sh_pkg.sv
sh_alu.sv
sh_sr_unit.sv
sh_mem_align.sv
sh_ma_ctrl.sv
sh_exec_core.sv
tb_sh_exec_core.sv

// File: Bender.yml
package:
  name: sh_exec_core

sources:
  - sh_pkg.sv
  - sh_alu.sv
  - sh_sr_unit.sv
  - sh_mem_align.sv
  - sh_ma_ctrl.sv
  - sh_exec_core.sv
  - target: test
    files:
      - tb_sh_exec_core.sv
